//--- hdl/axi_wr_defines.svh
`ifndef AXI_WR_DEFINES_SVH
`define AXI_WR_DEFINES_SVH

// Word address into the write memory
`define AXI_WR_ADDR_W 8

// Width of one data beat
`define AXI_WR_DATA_W 32

// Zero-based burst length, so a value of 0 is a single beat
`define AXI_WR_LEN_W 4

// Transaction id carried from the address channel to the response
`define AXI_WR_ID_W 4

// Number of memory words, one per address
`define AXI_WR_MEM_DEPTH 256

`endif

//--- hdl/axi_wr_pkg.sv
`include "axi_wr_defines.svh"

package axi_wr_pkg;

    // Plain vectors for each field that has a meaning of its own
    typedef logic [`AXI_WR_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_WR_DATA_W-1:0] data_t;
    typedef logic [`AXI_WR_LEN_W-1:0]  len_t;
    typedef logic [`AXI_WR_ID_W-1:0]   id_t;

    // Address channel word
    // Length is zero-based, as on AXI
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } aw_t;

    // Data channel word
    // The last flag from upstream is not trusted and gets rebuilt in the shim
    typedef struct packed {
        data_t data;
        logic  last;
    } w_t;

    // Write response codes use the same encodings as AXI
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage

//--- hdl/axi_wr_if.sv
interface axi_wr_if;
    import axi_wr_pkg::*;

    // Address channel
    aw_t   aw;
    logic  awvalid;
    logic  awready;

    // Data channel
    w_t    w;
    logic  wvalid;
    logic  wready;

    // Response channel carries one response per burst
    id_t   bid;
    resp_e bresp;
    logic  bvalid;
    logic  bready;

    // Side that issues bursts and consumes responses
    modport master (
        output aw,
        output awvalid,
        input  awready,
        output w,
        output wvalid,
        input  wready,
        input  bid,
        input  bresp,
        input  bvalid,
        output bready
    );

    // Side that accepts bursts and produces responses
    modport slave (
        input  aw,
        input  awvalid,
        output awready,
        input  w,
        input  wvalid,
        output wready,
        output bid,
        output bresp,
        output bvalid,
        input  bready
    );

endinterface

//--- hdl/prim_fifo2.sv
module prim_fifo2 #(
    parameter int N_DATA_BITS = 32
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   not_full,
    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    // Slot 0 is always the head, slot 1 only fills behind it
    logic [N_DATA_BITS-1:0] slot0;
    logic [N_DATA_BITS-1:0] slot1;
    logic                   valid0;
    logic                   valid1;

    // Stays low through reset so the FIFO refuses writes until it is running
    logic                   live;

    // Head is visible without a dequeue as first-word fall-through
    assign first     = slot0;
    assign not_empty = valid0;
    assign not_full  = live && !valid1;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            live   <= 1'b0;
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else
        begin
            live <= 1'b1;
            if (deq_en)
            begin
                // A full FIFO cannot enqueue, so the tail simply moves up
                valid0 <= valid1 || enq_en;
                valid1 <= 1'b0;
            end
            else if (enq_en)
            begin
                valid0 <= 1'b1;
                valid1 <= valid0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        // New word bypasses slot 1 when the head is leaving or empty
        if (deq_en)
            slot0 <= valid1 ? slot1 : enq_data;
        else if (enq_en && !valid0)
            slot0 <= enq_data;
        if (enq_en && valid0 && !deq_en)
            slot1 <= enq_data;
    end

    // The producer must honor not_full and the consumer not_empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) enq_en |-> not_full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) deq_en |-> not_empty);

endmodule

//--- hdl/burstcount0_sop_tracker.sv
module burstcount0_sop_tracker (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flit_valid,
    input  axi_wr_pkg::len_t burstcount,
    output logic             sop,
    output logic             eop
);
    import axi_wr_pkg::*;

    // Index of the next beat inside the current burst
    len_t beat_cnt;
    // Length captured from the start beat since burstcount is not held after that
    len_t len_q;
    logic sop_q;

    assign sop = sop_q;

    // On a start beat the length comes straight from the address word
    assign eop = sop_q ? (burstcount == '0) : (beat_cnt == len_q);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sop_q    <= 1'b1;
            beat_cnt <= '0;
            len_q    <= '0;
        end
        else if (flit_valid)
        begin
            // The beat after an end beat always opens a new burst
            sop_q <= eop;
            if (sop_q)
            begin
                len_q    <= burstcount;
                beat_cnt <= len_t'(1);
            end
            else
                beat_cnt <= beat_cnt + len_t'(1);
        end
    end

    // A beat can only open and close a burst when the burst is one beat long
    a_single_beat: assert property (@(posedge clk) disable iff (!arst_n)
        flit_valid && sop && eop |-> burstcount == '0);

endmodule

//--- hdl/axi_fixup_wlast.sv
module axi_fixup_wlast (
    input  logic     clk,
    input  logic     arst_n,
    axi_wr_if.slave  up,
    axi_wr_if.master dn
);
    import axi_wr_pkg::*;

    logic aw_avail;
    logic w_avail;
    logic w_sop;
    logic w_eop;
    logic aw_deq;
    logic w_deq;
    w_t   w_head;

    // Responses need no fixing and pass straight through
    assign up.bid    = dn.bid;
    assign up.bresp  = dn.bresp;
    assign up.bvalid = dn.bvalid;
    assign dn.bready = up.bready;

    // An address leaves only when the first beat of its burst is at the data head.
    // This keeps the two streams lined up burst by burst
    assign dn.awvalid = aw_avail && w_avail && w_sop;

    // Mid-burst beats flow freely while a start beat waits for its address
    assign dn.wvalid = w_avail && (!w_sop || aw_avail);

    assign aw_deq = dn.awvalid && dn.awready;
    assign w_deq  = dn.wvalid && dn.wready;

    prim_fifo2 #(
        .N_DATA_BITS($bits(aw_t))
    ) aw_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .enq_data  (up.aw),
        .enq_en    (up.awvalid && up.awready),
        .not_full  (up.awready),
        .first     (dn.aw),
        .deq_en    (aw_deq),
        .not_empty (aw_avail)
    );

    prim_fifo2 #(
        .N_DATA_BITS($bits(w_t))
    ) w_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .enq_data  (up.w),
        .enq_en    (up.wvalid && up.wready),
        .not_full  (up.wready),
        .first     (w_head),
        .deq_en    (w_deq),
        .not_empty (w_avail)
    );

    // Payload goes through unchanged, only the last flag is rebuilt
    always_comb
    begin
        dn.w      = w_head;
        dn.w.last = w_eop;
    end

    // Length is read from the address head, which belongs to the current
    // burst whenever a start beat is accepted
    burstcount0_sop_tracker sop_tracker (
        .clk        (clk),
        .arst_n     (arst_n),
        .flit_valid (w_deq),
        .burstcount (dn.aw.len),
        .sop        (w_sop),
        .eop        (w_eop)
    );

    // Downstream must take address and start beat on the same edge, or not at all
    a_aw_with_sop: assert property (@(posedge clk) disable iff (!arst_n)
        aw_deq == (w_deq && w_sop));

endmodule

//--- hdl/axi_wr_mem.sv
`include "axi_wr_defines.svh"

module axi_wr_mem (
    input  logic              clk,
    input  logic              arst_n,
    axi_wr_if.slave           bus,
    input  axi_wr_pkg::addr_t rd_addr,
    output axi_wr_pkg::data_t rd_data
);
    import axi_wr_pkg::*;

    typedef enum logic {
        IDLE,
        BURST
    } state_e;

    localparam int RESP_W = `AXI_WR_ID_W + 2;

    state_e              state;
    data_t               mem [`AXI_WR_MEM_DEPTH];
    id_t                 id_q;
    len_t                len_q;
    len_t                beat_cnt;
    addr_t               next_addr;
    logic                err_q;
    logic                aw_fire;
    logic                w_fire;
    logic                in_idle;
    addr_t               wr_addr;
    id_t                 cur_id;
    len_t                cur_len;
    len_t                cur_beat;
    logic                cur_err;
    resp_e               push_resp;
    logic [RESP_W-1:0]   resp_head;
    logic                q_not_full;

    // Both channels stall together and only when no room is left for a response
    assign bus.awready = q_not_full;
    assign bus.wready  = q_not_full;

    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign in_idle = (state == IDLE);

    // In IDLE the burst context comes from the address arriving with the first beat
    assign cur_id   = in_idle ? bus.aw.id : id_q;
    assign cur_len  = in_idle ? bus.aw.len : len_q;
    assign wr_addr  = in_idle ? bus.aw.addr : next_addr;
    assign cur_beat = in_idle ? '0 : beat_cnt;
    assign cur_err  = in_idle ? 1'b0 : err_q;

    assign push_resp = cur_err ? SLVERR : OKAY;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end
        else if (w_fire)
        begin
            state    <= bus.w.last ? IDLE : BURST;
            beat_cnt <= cur_beat + len_t'(1);
            // A non-last beat at the top address means the next one wraps to 0
            err_q    <= cur_err || (wr_addr == '1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (w_fire)
        begin
            mem[wr_addr] <= bus.w.data;
            id_q         <= cur_id;
            len_q        <= cur_len;
            next_addr    <= wr_addr + addr_t'(1);
        end
    end

    assign rd_data = mem[rd_addr];

    // Response queue holds {id, resp} entries
    prim_fifo2 #(
        .N_DATA_BITS(RESP_W)
    ) resp_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .enq_data  ({cur_id, push_resp}),
        .enq_en    (w_fire && bus.w.last),
        .not_full  (q_not_full),
        .first     (resp_head),
        .deq_en    (bus.bvalid && bus.bready),
        .not_empty (bus.bvalid)
    );

    assign bus.bid   = id_t'(resp_head[RESP_W-1:2]);
    assign bus.bresp = resp_e'(resp_head[1:0]);

    // The rebuilt last flag must land on the beat the address length predicts
    a_last_count: assert property (@(posedge clk) disable iff (!arst_n)
        w_fire && bus.w.last |-> cur_beat == cur_len);
    // a burst never opens without its address
    a_start_has_addr: assert property (@(posedge clk) disable iff (!arst_n)
        in_idle && w_fire |-> aw_fire);

endmodule

//--- hdl/axi_wlast_top.sv
module axi_wlast_top (
    input  logic              clk,
    input  logic              arst_n,
    input  axi_wr_pkg::id_t   aw_id,
    input  axi_wr_pkg::addr_t aw_addr,
    input  axi_wr_pkg::len_t  aw_len,
    input  logic              awvalid,
    output logic              awready,
    input  axi_wr_pkg::data_t w_data,
    input  logic              wvalid,
    output logic              wready,
    output axi_wr_pkg::id_t   bid,
    output axi_wr_pkg::resp_e bresp,
    output logic              bvalid,
    input  logic              bready,
    input  axi_wr_pkg::addr_t rd_addr,
    output axi_wr_pkg::data_t rd_data
);

    // Upstream side of the shim and the link from shim to memory
    axi_wr_if up_if ();
    axi_wr_if dn_if ();

    assign up_if.aw      = '{id: aw_id, addr: aw_addr, len: aw_len};
    assign up_if.awvalid = awvalid;
    assign awready       = up_if.awready;

    // The master gives no last flag, the shim supplies it from the burst length
    assign up_if.w       = '{data: w_data, last: 1'b0};
    assign up_if.wvalid  = wvalid;
    assign wready        = up_if.wready;

    assign bid           = up_if.bid;
    assign bresp         = up_if.bresp;
    assign bvalid        = up_if.bvalid;
    assign up_if.bready  = bready;

    axi_fixup_wlast u_fixup (
        .clk    (clk),
        .arst_n (arst_n),
        .up     (up_if.slave),
        .dn     (dn_if.master)
    );

    axi_wr_mem u_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus     (dn_if.slave),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- tb/tb_axi_wlast.sv
`include "axi_wr_defines.svh"

module tb_axi_wlast;
    import axi_wr_pkg::*;

    localparam int N_BURSTS       = 64;
    localparam int TIMEOUT_CYCLES = N_BURSTS * 40;
    localparam int DEPTH          = `AXI_WR_MEM_DEPTH;

    logic  clk;
    logic  arst_n;
    id_t   aw_id;
    addr_t aw_addr;
    len_t  aw_len;
    logic  awvalid;
    logic  awready;
    data_t w_data;
    logic  wvalid;
    logic  wready;
    id_t   bid;
    resp_e bresp;
    logic  bvalid;
    logic  bready;
    addr_t rd_addr;
    data_t rd_data;

    // Burst list in address-channel order, which is also the response order
    id_t   b_id   [N_BURSTS];
    addr_t b_addr [N_BURSTS];
    len_t  b_len  [N_BURSTS];
    resp_e b_resp [N_BURSTS];
    data_t beat_data [$];

    // Reference memory where only written words are compared at the end
    data_t model_mem [DEPTH];
    bit    written   [DEPTH];

    int errors;
    int resp_count;
    int cycle_cnt;
    bit first_done;

    axi_wlast_top u_axi_wlast_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Four stimulus phases of 16 bursts each
    // 0 plain traffic, 1 late addresses, 2 late data, 3 bready mostly low
    function automatic int phase_of(int b);
        return (b / 16) % 4;
    endfunction

    task automatic print_summary();
        $display("errors: %0d, responses: %0d of %0d, cycles: %0d",
                 errors, resp_count, N_BURSTS, cycle_cnt);
    endtask

    // Bursts, data and the expected memory image all come from the seed up front
    task automatic make_bursts();
        int   b;
        int   k;
        addr_t a;
        data_t d;
        for (b = 0; b < N_BURSTS; b++)
        begin
            b_id[b] = id_t'($urandom_range(15));
            // Some starts sit near the top so that bursts run over the end
            if ($urandom_range(5) == 0)
                b_addr[b] = addr_t'($urandom_range(DEPTH - 1, DEPTH - 16));
            else
                b_addr[b] = addr_t'($urandom_range(DEPTH - 1));
            // Single-beat bursts are mixed in on purpose
            b_len[b] = ($urandom_range(3) == 0) ? len_t'(0) : len_t'($urandom_range(15));
            b_resp[b] = (int'(b_addr[b]) + int'(b_len[b]) > DEPTH - 1) ? SLVERR : OKAY;
            for (k = 0; k <= int'(b_len[b]); k++)
            begin
                d = $urandom();
                beat_data.push_back(d);
                // Beat k goes to start plus k, wrapping at the top
                a = b_addr[b] + addr_t'(k);
                model_mem[a] = d;
                written[a] = 1'b1;
            end
        end
    endtask

    // Ready only depends on registered state, so at the falling edge it already
    // tells whether the word on the bus is taken at the next rising edge
    task automatic drive_addr();
        int b;
        int gap;
        for (b = 0; b < N_BURSTS; b++)
        begin
            gap = (phase_of(b) == 1) ? $urandom_range(20, 8) : $urandom_range(2);
            awvalid = 1'b0;
            repeat (gap) @(negedge clk);
            awvalid = 1'b1;
            aw_id   = b_id[b];
            aw_addr = b_addr[b];
            aw_len  = b_len[b];
            while (!awready)
                @(negedge clk);
            @(negedge clk);
        end
        awvalid = 1'b0;
    endtask

    task automatic drive_data();
        int b;
        int k;
        int gap;
        int idx;
        idx = 0;
        for (b = 0; b < N_BURSTS; b++)
        begin
            for (k = 0; k <= int'(b_len[b]); k++)
            begin
                if (k == 0 && phase_of(b) == 2)
                    gap = $urandom_range(20, 8);
                else if ($urandom_range(3) == 0)
                    gap = $urandom_range(3, 1);
                else
                    gap = 0;
                wvalid = 1'b0;
                repeat (gap) @(negedge clk);
                wvalid = 1'b1;
                w_data = beat_data[idx];
                while (!wready)
                    @(negedge clk);
                idx++;
                // No response may show up before the first burst is fully sent
                if (b == 0 && k == int'(b_len[0]))
                    first_done = 1'b1;
                @(negedge clk);
            end
        end
        wvalid = 1'b0;
    endtask

    // Responses are drawn and checked on the falling edge too
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            if (awready || wready || bvalid)
            begin
                $display("ready or bvalid seen high during reset");
                errors++;
            end
        end
        else
        begin
            if (phase_of(resp_count) == 3)
                bready = ($urandom_range(7) == 0);
            else
                bready = ($urandom_range(3) != 0);
            if (bvalid && !first_done)
            begin
                $display("bvalid rose before any burst was complete");
                errors++;
            end
            if (bvalid && bready)
            begin
                if (resp_count >= N_BURSTS)
                begin
                    $display("response received beyond the burst count");
                    errors++;
                end
                else
                begin
                    if (bid !== b_id[resp_count])
                    begin
                        $display("[FAIL] bid got 0x%h expected 0x%h (burst %0d)",
                                 bid, b_id[resp_count], resp_count);
                        errors++;
                    end
                    if (bresp !== b_resp[resp_count])
                    begin
                        $display("[FAIL] bresp got 0x%h expected 0x%h (burst %0d)",
                                 bresp, b_resp[resp_count], resp_count);
                        errors++;
                    end
                end
                resp_count++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, responses still missing", cycle_cnt);
            errors++;
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        int a;
        void'($urandom(32'hdcddbb0d));
        arst_n     = 1'b0;
        aw_id      = '0;
        aw_addr    = '0;
        aw_len     = '0;
        awvalid    = 1'b0;
        w_data     = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        rd_addr    = '0;
        errors     = 0;
        resp_count = 0;
        cycle_cnt  = 0;
        first_done = 1'b0;
        make_bursts();

        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Address and data channels run on their own
        fork
            drive_addr();
            drive_data();
        join

        while (resp_count < N_BURSTS)
            @(negedge clk);
        // Give any stray extra response a chance to appear
        repeat (10) @(negedge clk);

        // Read back every word the model saw written
        for (a = 0; a < DEPTH; a++)
        begin
            if (written[a])
            begin
                @(negedge clk);
                rd_addr = addr_t'(a);
                @(posedge clk);
                if (rd_data !== model_mem[a])
                begin
                    $display("[FAIL] rd_data at 0x%h got 0x%h expected 0x%h",
                             a[7:0], rd_data, model_mem[a]);
                    errors++;
                end
            end
        end

        print_summary();
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/axi_wr_pkg.sv
hdl/axi_wr_if.sv
hdl/prim_fifo2.sv
hdl/burstcount0_sop_tracker.sv
hdl/axi_fixup_wlast.sv
hdl/axi_wr_mem.sv
hdl/axi_wlast_top.sv
tb/tb_axi_wlast.sv
